// File: logic/rob_cfg.svh
// row count must be a power of two so the row pointers wrap without extra logic
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// rows in flight, one group of lanes per row
`define ROB_ROWS 8

// micro-ops per row, also the number of bank instances
`define ROB_LANES 4

// physical register index width
`define ROB_PREG_W 7

// one bit per unresolved branch
`define ROB_BRM_W 4

`endif

// File: logic/rob_pkg.sv
// widths follow rob_cfg.svh and a tag is only meaningful while its row is occupied
`include "rob_cfg.svh"

package rob_pkg;

	// pc bits below this are rebuilt from the lane index
	localparam int PC_LSB = 4;

	typedef logic [$clog2(`ROB_ROWS)-1:0]  row_t;
	typedef logic [$clog2(`ROB_LANES)-1:0] lane_t;
	// row in the upper bits, lane below
	typedef logic [$bits(row_t)+$bits(lane_t)-1:0] tag_t;
	typedef logic [`ROB_PREG_W-1:0] preg_t;
	typedef logic [`ROB_BRM_W-1:0]  brmask_t;
	typedef logic [31-PC_LSB:0]     pcbase_t;

	function automatic row_t tag_row(tag_t tag);
		return tag[$bits(tag_t)-1 -: $bits(row_t)];
	endfunction

	function automatic lane_t tag_lane(tag_t tag);
		return tag[$bits(lane_t)-1:0];
	endfunction

endpackage

// File: logic/rob_dispatch.sv
// the core must hold its row stable while o_dis_ready is low, and i_retire must not fire when empty
`include "rob_cfg.svh"

module rob_dispatch (
	input  logic             i_clk,
	input  logic             i_rst_n,
	input  logic             i_dis_valid,
	input  rob_pkg::pcbase_t i_dis_pc,
	input  logic             i_retire,
	input  rob_pkg::row_t    i_head_row,
	output logic             o_dis_ready,
	output rob_pkg::row_t    o_dis_tag,
	output logic             o_dis_we,
	output rob_pkg::row_t    o_dis_row,
	output logic             o_occupied,
	output rob_pkg::pcbase_t o_head_pc
);

	import rob_pkg::*;

	localparam int CNT_W = $clog2(`ROB_ROWS + 1);

	row_t            tail;
	logic [CNT_W-1:0] count;
	logic            accept;
	pcbase_t         pc_mem [`ROB_ROWS];

	// ready drops only with every row taken, even when a retire is pending
	assign o_dis_ready = (count != CNT_W'(`ROB_ROWS));
	assign accept      = i_dis_valid & o_dis_ready;
	assign o_occupied  = (count != '0);

	assign o_dis_we  = accept;
	assign o_dis_row = tail;
	assign o_dis_tag = tail;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			tail  <= '0;
			count <= '0;
		end else begin
			if (accept)
				tail <= tail + 1'b1;
			case ({accept, i_retire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// one pc base per row, lanes add their own offset
	always_ff @(posedge i_clk) begin
		if (accept)
			pc_mem[tail] <= i_dis_pc;
	end

	assign o_head_pc = pc_mem[i_head_row];

endmodule

// File: logic/rob_bank.sv
// a write to a row overrides any busy clear or kill that lands on it at the same edge
`include "rob_cfg.svh"

module rob_bank #(
	parameter rob_pkg::lane_t BANK_ID = '0
) (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  logic              i_we,
	input  rob_pkg::row_t     i_row,
	input  logic              i_val,
	input  rob_pkg::preg_t    i_prdn,
	input  rob_pkg::preg_t    i_prdo,
	input  rob_pkg::brmask_t  i_mask,
	input  logic              i_wb_valid0,
	input  logic              i_wb_valid1,
	input  logic              i_wb_valid2,
	input  logic              i_wb_valid3,
	input  rob_pkg::tag_t     i_wb_tag0,
	input  rob_pkg::tag_t     i_wb_tag1,
	input  rob_pkg::tag_t     i_wb_tag2,
	input  rob_pkg::tag_t     i_wb_tag3,
	input  rob_pkg::brmask_t  i_brkill,
	input  rob_pkg::row_t     i_head_row,
	output logic              o_head_val,
	output logic              o_head_busy,
	output rob_pkg::preg_t    o_head_prdn,
	output rob_pkg::preg_t    o_head_prdo
);

	import rob_pkg::*;

	localparam int NWB = 4;

	logic [`ROB_ROWS-1:0] val;
	logic [`ROB_ROWS-1:0] busy;
	logic [`ROB_ROWS-1:0] busy_clr;
	logic [`ROB_ROWS-1:0] kill;
	preg_t                prdn [`ROB_ROWS];
	preg_t                prdo [`ROB_ROWS];
	brmask_t              mask [`ROB_ROWS];
	logic [NWB-1:0]       wb_valid;
	tag_t                 wb_tag [NWB];

	assign wb_valid = {i_wb_valid3, i_wb_valid2, i_wb_valid1, i_wb_valid0};
	assign wb_tag   = '{i_wb_tag0, i_wb_tag1, i_wb_tag2, i_wb_tag3};

	// only tags aimed at this lane touch the column
	always_comb begin
		busy_clr = '0;
		for (int p = 0; p < NWB; p++) begin
			if (wb_valid[p] && tag_lane(wb_tag[p]) == BANK_ID)
				busy_clr[tag_row(wb_tag[p])] = 1'b1;
		end
	end

	always_comb begin
		for (int r = 0; r < `ROB_ROWS; r++)
			kill[r] = |(mask[r] & i_brkill);
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			val  <= '0;
			busy <= '0;
		end else begin
			val  <= val & ~kill;
			busy <= busy & ~busy_clr;
			// new entries start busy when valid
			if (i_we) begin
				val[i_row]  <= i_val;
				busy[i_row] <= i_val;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_we) begin
			prdn[i_row] <= i_prdn;
			prdo[i_row] <= i_prdo;
			mask[i_row] <= i_mask;
		end
	end

	assign o_head_val  = val[i_head_row];
	assign o_head_busy = busy[i_head_row];
	assign o_head_prdn = prdn[i_head_row];
	assign o_head_prdo = prdo[i_head_row];

endmodule

// File: logic/rob_commit.sv
// whole rows retire one per cycle and the commit group cannot be stalled by the core
`include "rob_cfg.svh"

module rob_commit (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  logic                  i_occupied,
	input  logic [`ROB_LANES-1:0] i_head_val,
	input  logic [`ROB_LANES-1:0] i_head_busy,
	input  rob_pkg::preg_t        i_head_prdn0,
	input  rob_pkg::preg_t        i_head_prdn1,
	input  rob_pkg::preg_t        i_head_prdn2,
	input  rob_pkg::preg_t        i_head_prdn3,
	input  rob_pkg::preg_t        i_head_prdo0,
	input  rob_pkg::preg_t        i_head_prdo1,
	input  rob_pkg::preg_t        i_head_prdo2,
	input  rob_pkg::preg_t        i_head_prdo3,
	input  rob_pkg::pcbase_t      i_head_pc,
	output rob_pkg::row_t         o_head_row,
	output logic                  o_retire,
	output logic                  o_com_valid,
	output logic [`ROB_LANES-1:0] o_com_en,
	output rob_pkg::preg_t        o_com_prd0,
	output rob_pkg::preg_t        o_com_prd1,
	output rob_pkg::preg_t        o_com_prd2,
	output rob_pkg::preg_t        o_com_prd3,
	output rob_pkg::pcbase_t      o_com_pc
);

	import rob_pkg::*;

	preg_t                 prdn [`ROB_LANES];
	preg_t                 prdo [`ROB_LANES];
	preg_t                 sel  [`ROB_LANES];
	logic [`ROB_LANES-1:0] sel_en;
	row_t                  head;

	assign prdn = '{i_head_prdn0, i_head_prdn1, i_head_prdn2, i_head_prdn3};
	assign prdo = '{i_head_prdo0, i_head_prdo1, i_head_prdo2, i_head_prdo3};

	// killed entries hand back the new register, live ones the old
	always_comb begin
		for (int l = 0; l < `ROB_LANES; l++) begin
			sel[l]    = i_head_val[l] ? prdo[l] : prdn[l];
			sel_en[l] = |sel[l];
		end
	end

	// head row is done when no live entry is still waiting for writeback
	assign o_retire   = i_occupied & ~|(i_head_val & i_head_busy);
	assign o_head_row = head;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			head        <= '0;
			o_com_valid <= 1'b0;
			o_com_en    <= '0;
		end else begin
			o_com_valid <= o_retire;
			o_com_en    <= o_retire ? sel_en : '0;
			if (o_retire)
				head <= head + 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_retire) begin
			o_com_prd0 <= sel[0];
			o_com_prd1 <= sel[1];
			o_com_prd2 <= sel[2];
			o_com_prd3 <= sel[3];
			o_com_pc   <= i_head_pc;
		end
	end

endmodule

// File: logic/rob_top.sv
// writeback and kill are single-cycle pulses and must carry tags of rows still in flight
`include "rob_cfg.svh"

module rob_top (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  logic                  i_dis_valid,
	input  rob_pkg::pcbase_t      i_dis_pc,
	input  logic                  i_dis_val0,
	input  logic                  i_dis_val1,
	input  logic                  i_dis_val2,
	input  logic                  i_dis_val3,
	input  rob_pkg::preg_t        i_dis_prdn0,
	input  rob_pkg::preg_t        i_dis_prdn1,
	input  rob_pkg::preg_t        i_dis_prdn2,
	input  rob_pkg::preg_t        i_dis_prdn3,
	input  rob_pkg::preg_t        i_dis_prdo0,
	input  rob_pkg::preg_t        i_dis_prdo1,
	input  rob_pkg::preg_t        i_dis_prdo2,
	input  rob_pkg::preg_t        i_dis_prdo3,
	input  rob_pkg::brmask_t      i_dis_mask0,
	input  rob_pkg::brmask_t      i_dis_mask1,
	input  rob_pkg::brmask_t      i_dis_mask2,
	input  rob_pkg::brmask_t      i_dis_mask3,
	input  logic                  i_wb_valid0,
	input  logic                  i_wb_valid1,
	input  logic                  i_wb_valid2,
	input  logic                  i_wb_valid3,
	input  rob_pkg::tag_t         i_wb_tag0,
	input  rob_pkg::tag_t         i_wb_tag1,
	input  rob_pkg::tag_t         i_wb_tag2,
	input  rob_pkg::tag_t         i_wb_tag3,
	input  rob_pkg::brmask_t      i_brkill,
	output logic                  o_dis_ready,
	output rob_pkg::row_t         o_dis_tag,
	output logic                  o_com_valid,
	output logic [`ROB_LANES-1:0] o_com_en,
	output rob_pkg::preg_t        o_com_prd0,
	output rob_pkg::preg_t        o_com_prd1,
	output rob_pkg::preg_t        o_com_prd2,
	output rob_pkg::preg_t        o_com_prd3,
	output rob_pkg::pcbase_t      o_com_pc
);

	import rob_pkg::*;

	logic                  dis_we;
	row_t                  dis_row;
	row_t                  head_row;
	logic                  retire;
	logic                  occupied;
	pcbase_t               head_pc;
	logic [`ROB_LANES-1:0] dis_val;
	preg_t                 dis_prdn [`ROB_LANES];
	preg_t                 dis_prdo [`ROB_LANES];
	brmask_t               dis_mask [`ROB_LANES];
	logic [`ROB_LANES-1:0] head_val;
	logic [`ROB_LANES-1:0] head_busy;
	preg_t                 head_prdn [`ROB_LANES];
	preg_t                 head_prdo [`ROB_LANES];

	assign dis_val  = {i_dis_val3, i_dis_val2, i_dis_val1, i_dis_val0};
	assign dis_prdn = '{i_dis_prdn0, i_dis_prdn1, i_dis_prdn2, i_dis_prdn3};
	assign dis_prdo = '{i_dis_prdo0, i_dis_prdo1, i_dis_prdo2, i_dis_prdo3};
	assign dis_mask = '{i_dis_mask0, i_dis_mask1, i_dis_mask2, i_dis_mask3};

	rob_dispatch u_dispatch (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_dis_valid (i_dis_valid),
		.i_dis_pc    (i_dis_pc),
		.i_retire    (retire),
		.i_head_row  (head_row),
		.o_dis_ready (o_dis_ready),
		.o_dis_tag   (o_dis_tag),
		.o_dis_we    (dis_we),
		.o_dis_row   (dis_row),
		.o_occupied  (occupied),
		.o_head_pc   (head_pc)
	);

	for (genvar g = 0; g < `ROB_LANES; g++) begin : g_bank
		rob_bank #(.BANK_ID(lane_t'(g))) u_bank (
			.i_clk       (i_clk),
			.i_rst_n     (i_rst_n),
			.i_we        (dis_we),
			.i_row       (dis_row),
			.i_val       (dis_val[g]),
			.i_prdn      (dis_prdn[g]),
			.i_prdo      (dis_prdo[g]),
			.i_mask      (dis_mask[g]),
			.i_wb_valid0 (i_wb_valid0),
			.i_wb_valid1 (i_wb_valid1),
			.i_wb_valid2 (i_wb_valid2),
			.i_wb_valid3 (i_wb_valid3),
			.i_wb_tag0   (i_wb_tag0),
			.i_wb_tag1   (i_wb_tag1),
			.i_wb_tag2   (i_wb_tag2),
			.i_wb_tag3   (i_wb_tag3),
			.i_brkill    (i_brkill),
			.i_head_row  (head_row),
			.o_head_val  (head_val[g]),
			.o_head_busy (head_busy[g]),
			.o_head_prdn (head_prdn[g]),
			.o_head_prdo (head_prdo[g])
		);
	end

	rob_commit u_commit (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_occupied   (occupied),
		.i_head_val   (head_val),
		.i_head_busy  (head_busy),
		.i_head_prdn0 (head_prdn[0]),
		.i_head_prdn1 (head_prdn[1]),
		.i_head_prdn2 (head_prdn[2]),
		.i_head_prdn3 (head_prdn[3]),
		.i_head_prdo0 (head_prdo[0]),
		.i_head_prdo1 (head_prdo[1]),
		.i_head_prdo2 (head_prdo[2]),
		.i_head_prdo3 (head_prdo[3]),
		.i_head_pc    (head_pc),
		.o_head_row   (head_row),
		.o_retire     (retire),
		.o_com_valid  (o_com_valid),
		.o_com_en     (o_com_en),
		.o_com_prd0   (o_com_prd0),
		.o_com_prd1   (o_com_prd1),
		.o_com_prd2   (o_com_prd2),
		.o_com_prd3   (o_com_prd3),
		.o_com_pc     (o_com_pc)
	);

endmodule

// File: tb/rob_assertions.sv
// bound into rob_top, checks are sampled on the rising clock and idle while reset is low
`include "rob_cfg.svh"

module rob_assertions (
	input logic                  i_clk,
	input logic                  i_rst_n,
	input logic                  i_dis_valid,
	input logic                  i_dis_ready,
	input rob_pkg::row_t         i_dis_tag,
	input logic                  i_com_valid,
	input logic [`ROB_LANES-1:0] i_com_en
);

	import rob_pkg::*;

	// commit registers come out of reset idle
	a_idle_after_reset: assert property (@(posedge i_clk)
		!i_rst_n |=> (!i_com_valid && i_com_en == '0))
		else $error("commit outputs active in the first cycle after reset");

	a_en_with_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_com_en != '0) |-> i_com_valid)
		else $error("commit enable high without a commit pulse");

	a_tag_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(i_dis_valid && i_dis_ready) |=> $stable(i_dis_tag))
		else $error("dispatch tag moved without an accepted row");

	// tail wraps with the row count
	a_tag_step: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_dis_valid && i_dis_ready) |=> i_dis_tag == row_t'($past(i_dis_tag) + 1'b1))
		else $error("dispatch tag did not step after an accepted row");

endmodule

bind rob_top rob_assertions u_rob_assertions (
	.i_clk       (i_clk),
	.i_rst_n     (i_rst_n),
	.i_dis_valid (i_dis_valid),
	.i_dis_ready (o_dis_ready),
	.i_dis_tag   (o_dis_tag),
	.i_com_valid (o_com_valid),
	.i_com_en    (o_com_en)
);

// File: tb/rob_tb.sv
// reads tb/rob_trace.txt relative to the project root, and kill and full records wait until all expected commits are out
`include "rob_cfg.svh"

module rob_tb;

	import rob_pkg::*;

	localparam int ROWS  = `ROB_ROWS;
	localparam int LANES = `ROB_LANES;
	localparam int PW    = `ROB_PREG_W;

	logic             clk;
	logic             rst_n;
	logic             dis_valid;
	pcbase_t          dis_pc;
	logic [LANES-1:0] dis_val;
	preg_t            dis_prdn [LANES];
	preg_t            dis_prdo [LANES];
	brmask_t          dis_mask [LANES];
	logic [3:0]       wb_valid;
	tag_t             wb_tag [4];
	brmask_t          brkill;
	logic             dis_ready;
	row_t             dis_tag;
	logic             com_valid;
	logic [LANES-1:0] com_en;
	preg_t            com_prd [LANES];
	pcbase_t          com_pc;

	// reference model of the buffer, indexed by row and lane
	logic    m_val  [ROWS][LANES];
	logic    m_busy [ROWS][LANES];
	preg_t   m_prdn [ROWS][LANES];
	preg_t   m_prdo [ROWS][LANES];
	brmask_t m_mask [ROWS][LANES];
	pcbase_t m_pc   [ROWS];
	int      m_head;
	int      m_count;
	int      accepted;

	logic [LANES-1:0]    exp_en  [$];
	logic [LANES*PW-1:0] exp_prd [$];
	pcbase_t             exp_pc  [$];

	string lines [$];
	int    mismatches;
	int    others;
	int    commits;
	bit    trace_ready;
	bit    saw_end;

	rob_top dut_i (
		.i_clk       (clk),
		.i_rst_n     (rst_n),
		.i_dis_valid (dis_valid),
		.i_dis_pc    (dis_pc),
		.i_dis_val0  (dis_val[0]),
		.i_dis_val1  (dis_val[1]),
		.i_dis_val2  (dis_val[2]),
		.i_dis_val3  (dis_val[3]),
		.i_dis_prdn0 (dis_prdn[0]),
		.i_dis_prdn1 (dis_prdn[1]),
		.i_dis_prdn2 (dis_prdn[2]),
		.i_dis_prdn3 (dis_prdn[3]),
		.i_dis_prdo0 (dis_prdo[0]),
		.i_dis_prdo1 (dis_prdo[1]),
		.i_dis_prdo2 (dis_prdo[2]),
		.i_dis_prdo3 (dis_prdo[3]),
		.i_dis_mask0 (dis_mask[0]),
		.i_dis_mask1 (dis_mask[1]),
		.i_dis_mask2 (dis_mask[2]),
		.i_dis_mask3 (dis_mask[3]),
		.i_wb_valid0 (wb_valid[0]),
		.i_wb_valid1 (wb_valid[1]),
		.i_wb_valid2 (wb_valid[2]),
		.i_wb_valid3 (wb_valid[3]),
		.i_wb_tag0   (wb_tag[0]),
		.i_wb_tag1   (wb_tag[1]),
		.i_wb_tag2   (wb_tag[2]),
		.i_wb_tag3   (wb_tag[3]),
		.i_brkill    (brkill),
		.o_dis_ready (dis_ready),
		.o_dis_tag   (dis_tag),
		.o_com_valid (com_valid),
		.o_com_en    (com_en),
		.o_com_prd0  (com_prd[0]),
		.o_com_prd1  (com_prd[1]),
		.o_com_prd2  (com_prd[2]),
		.o_com_prd3  (com_prd[3]),
		.o_com_pc    (com_pc)
	);

	always #5 clk = ~clk;

	function automatic bit row_done(int r);
		bit done;
		done = 1'b1;
		for (int l = 0; l < LANES; l++) begin
			if (m_val[r][l] && m_busy[r][l])
				done = 1'b0;
		end
		return done;
	endfunction

	// live lanes free the old register, killed lanes the new one, zero is never freed
	task automatic push_ready_rows();
		logic [LANES-1:0]    en;
		logic [LANES*PW-1:0] prd;
		preg_t               sel;
		while (m_count > 0 && row_done(m_head)) begin
			for (int l = 0; l < LANES; l++) begin
				sel = m_val[m_head][l] ? m_prdo[m_head][l] : m_prdn[m_head][l];
				prd[l*PW +: PW] = sel;
				en[l] = (sel != '0);
			end
			exp_en.push_back(en);
			exp_prd.push_back(prd);
			exp_pc.push_back(m_pc[m_head]);
			m_head = (m_head + 1) % ROWS;
			m_count--;
		end
	endtask

	task automatic wait_drain();
		while (exp_en.size() != 0)
			@(negedge clk);
	endtask

	task automatic dispatch_row(string line);
		logic [31:0] pc;
		logic [31:0] f [16];
		int          n;
		int          r;
		n = $sscanf(line, "D %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", pc,
			f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
			f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
		assert (n == 17) else begin
			others++;
			$display("dispatch record has %0d fields instead of 17", n);
		end
		dis_pc = pcbase_t'(pc);
		for (int l = 0; l < LANES; l++) begin
			dis_val[l]  = f[4*l][0];
			dis_prdn[l] = preg_t'(f[4*l+1]);
			dis_prdo[l] = preg_t'(f[4*l+2]);
			dis_mask[l] = brmask_t'(f[4*l+3]);
		end
		dis_valid = 1'b1;
		// hold the row until the buffer has room
		while (!dis_ready)
			@(negedge clk);
		assert (dis_tag == row_t'(accepted % ROWS)) else begin
			mismatches++;
			$display("[FAIL] o_dis_tag got %h expected %h", dis_tag, row_t'(accepted % ROWS));
		end
		@(negedge clk);
		dis_valid = 1'b0;
		r = accepted % ROWS;
		m_pc[r] = dis_pc;
		for (int l = 0; l < LANES; l++) begin
			m_val[r][l]  = dis_val[l];
			m_busy[r][l] = dis_val[l];
			m_prdn[r][l] = dis_prdn[l];
			m_prdo[r][l] = dis_prdo[l];
			m_mask[r][l] = dis_mask[l];
		end
		accepted++;
		m_count++;
		push_ready_rows();
	endtask

	task automatic send_writeback(tag_t tag);
		int port;
		port = $urandom % 4;
		wb_valid[port] = 1'b1;
		wb_tag[port]   = tag;
		m_busy[tag / LANES][tag % LANES] = 1'b0;
		push_ready_rows();
		@(negedge clk);
		wb_valid[port] = 1'b0;
	endtask

	task automatic kill_branches(brmask_t kmask);
		int r;
		wait_drain();
		brkill = kmask;
		for (int i = 0; i < m_count; i++) begin
			r = (m_head + i) % ROWS;
			for (int l = 0; l < LANES; l++) begin
				if ((m_mask[r][l] & kmask) != '0)
					m_val[r][l] = 1'b0;
			end
		end
		push_ready_rows();
		@(negedge clk);
		brkill = '0;
	endtask

	task automatic expect_full();
		wait_drain();
		assert (dis_ready == 1'b0) else begin
			mismatches++;
			$display("[FAIL] o_dis_ready got %h expected %h", dis_ready, 1'b0);
		end
		assert (dis_tag == row_t'(accepted % ROWS)) else begin
			mismatches++;
			$display("[FAIL] o_dis_tag got %h expected %h", dis_tag, row_t'(accepted % ROWS));
		end
	endtask

	task automatic run_record(string line);
		logic [31:0] v;
		case (line.getc(0))
			"D": dispatch_row(line);
			"W": begin
				void'($sscanf(line, "W %h", v));
				send_writeback(tag_t'(v));
			end
			"K": begin
				void'($sscanf(line, "K %h", v));
				kill_branches(brmask_t'(v));
			end
			"F": expect_full();
			"E": saw_end = 1'b1;
			default: begin
				others++;
				$display("unknown trace record: %s", line);
			end
		endcase
	endtask

	// commit groups must leave in dispatch order
	always @(negedge clk) begin : monitor
		logic [LANES-1:0]    en;
		logic [LANES*PW-1:0] prd;
		pcbase_t             pc;
		if (rst_n && com_valid) begin
			assert (exp_en.size() != 0) else begin
				others++;
				$display("commit pulse arrived while no row was expected to retire");
			end
			if (exp_en.size() != 0) begin
				en  = exp_en.pop_front();
				prd = exp_prd.pop_front();
				pc  = exp_pc.pop_front();
				commits++;
				assert (com_en === en) else begin
					mismatches++;
					$display("[FAIL] o_com_en got %h expected %h", com_en, en);
				end
				for (int l = 0; l < LANES; l++) begin
					assert (com_prd[l] === prd[l*PW +: PW]) else begin
						mismatches++;
						$display("[FAIL] o_com_prd%0d got %h expected %h", l, com_prd[l],
							prd[l*PW +: PW]);
					end
				end
				assert (com_pc === pc) else begin
					mismatches++;
					$display("[FAIL] o_com_pc got %h expected %h", com_pc, pc);
				end
			end
		end
	end

	initial begin : watchdog
		int limit;
		wait (trace_ready);
		limit = lines.size() * 20 + 200;
		repeat (limit) @(posedge clk);
		others++;
		$display("timeout after %0d cycles before the trace finished", limit);
		$display("commits %0d, value mismatches %0d, other failures %0d",
			commits, mismatches, others);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin : stimulus
		int    fd;
		string line;
		int    gap;
		clk       = 1'b0;
		rst_n     = 1'b0;
		dis_valid = 1'b0;
		dis_pc    = '0;
		dis_val   = '0;
		wb_valid  = '0;
		brkill    = '0;
		for (int l = 0; l < LANES; l++) begin
			dis_prdn[l] = '0;
			dis_prdo[l] = '0;
			dis_mask[l] = '0;
			wb_tag[l]   = '0;
		end
		mismatches = 0;
		others     = 0;
		commits    = 0;
		m_head     = 0;
		m_count    = 0;
		accepted   = 0;
		saw_end    = 1'b0;
		void'($urandom(32'h272e));
		fd = $fopen("tb/rob_trace.txt", "r");
		if (fd == 0) begin
			others++;
			$display("cannot open tb/rob_trace.txt");
		end else begin
			while ($fgets(line, fd)) begin
				if (line.len() > 1 && line.getc(0) != "#")
					lines.push_back(line);
			end
			$fclose(fd);
		end
		trace_ready = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		assert (dis_ready == 1'b1) else begin
			mismatches++;
			$display("[FAIL] o_dis_ready got %h expected %h", dis_ready, 1'b1);
		end
		for (int i = 0; i < lines.size() && !saw_end; i++) begin
			gap = $urandom % 4;
			repeat (gap) @(negedge clk);
			run_record(lines[i]);
		end
		assert (saw_end) else begin
			others++;
			$display("trace ran out without an end record");
		end
		wait_drain();
		repeat (4) @(negedge clk);
		assert (m_count == 0) else begin
			others++;
			$display("%0d rows never became ready to retire", m_count);
		end
		$display("commits %0d, value mismatches %0d, other failures %0d",
			commits, mismatches, others);
		if (mismatches == 0 && others == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: tb/rob_trace.txt
# D pc_base then per lane: valid new_preg old_preg mask, all hex | W tag = row*4+lane | K kill mask
# F expects the buffer full with the tail at accepted rows mod 8 | E ends the trace
D 0001000 1 20 10 0 1 21 11 0 1 22 12 0 1 23 13 0
D 0001001 1 24 14 0 1 25 15 0 0 00 00 0 1 27 17 0
W 00
W 01
W 02
W 03
W 04
W 05
W 07
D 0002000 1 28 18 0 1 29 19 0 1 2a 1a 0 1 2b 1b 0
D 0002001 1 2c 1c 0 1 2d 1d 0 1 2e 1e 0 1 2f 1f 0
W 0c
W 0d
W 0e
W 0f
W 08
W 09
W 0a
W 0b
D 0003000 1 30 20 1 1 31 21 2 1 32 22 0 1 33 23 3
D 0003001 1 34 24 4 1 35 25 4 1 36 26 4 1 37 27 c
W 10
W 12
K 2
K 4
D 0004000 1 38 00 0 1 39 28 0 1 3a 00 0 1 3b 29 0
W 18
W 19
W 1a
W 1b
D 0004001 1 00 2a 8 1 3d 2b 0 0 00 00 0 0 00 00 0
W 1d
K 8
D 0005000 1 40 30 0 0 00 00 0 0 00 00 0 0 00 00 0
D 0005001 1 41 31 0 0 00 00 0 0 00 00 0 0 00 00 0
D 0005002 1 42 32 0 0 00 00 0 0 00 00 0 0 00 00 0
D 0005003 1 43 33 0 0 00 00 0 0 00 00 0 0 00 00 0
D 0005004 1 44 34 0 0 00 00 0 0 00 00 0 0 00 00 0
D 0005005 1 45 35 0 0 00 00 0 0 00 00 0 0 00 00 0
D 0005006 1 46 36 0 0 00 00 0 0 00 00 0 0 00 00 0
D 0005007 1 47 37 0 0 00 00 0 0 00 00 0 0 00 00 0
F
W 00
D 0006000 1 50 48 0 0 00 00 0 0 00 00 0 0 00 00 0
W 04
W 08
W 0c
W 10
W 14
W 18
W 1c
W 00
E

// File: src.f
+incdir+logic
logic/rob_pkg.sv
logic/rob_dispatch.sv
logic/rob_bank.sv
logic/rob_commit.sv
logic/rob_top.sv
tb/rob_assertions.sv
tb/rob_tb.sv

// File: Bender.yml
package:
  name: rob

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/rob_pkg.sv
      - logic/rob_dispatch.sv
      - logic/rob_bank.sv
      - logic/rob_commit.sv
      - logic/rob_top.sv
      - target: test
        files:
          - tb/rob_assertions.sv
          - tb/rob_tb.sv
